// File: dv/int_controller_props.sv
/* Bound checker for the interrupt controller: port-level model of mie, mip and
   mstatus.MIE, with assertions on responses, wakeup, request and winner id. */

`timescale 1ns/100ps

module int_controller_props (
  input logic                         clk_i,
  input logic                         rst_i,
  input irq_pkg::irq_vec_t            irq_i,
  input logic                         csr_valid_i,
  input irq_pkg::csr_req_t            csr_req_i,
  input logic                         csr_rvalid_o,
  input irq_pkg::csr_rsp_t            csr_rsp_o,
  input logic                         m_irq_enable_o,
  input logic                         irq_req_o,
  input logic [irq_pkg::IRQ_ID_W-1:0] irq_id_o,
  input logic                         irq_wu_o
);

  irq_pkg::irq_vec_t            mdl_mip;
  irq_pkg::irq_vec_t            mdl_mie;
  logic                         mdl_en;
  irq_pkg::irq_vec_t            mdl_pend;
  irq_pkg::csr_rsp_t            exp_rsp;
  irq_pkg::csr_rsp_t            exp_rsp_q;
  logic [irq_pkg::IRQ_ID_W-1:0] exp_id;
  bit                           failed;

  // Fast lines from 31 down, then external, software, timer
  function automatic logic [irq_pkg::IRQ_ID_W-1:0] winner(input irq_pkg::irq_vec_t pend);
    logic [irq_pkg::IRQ_ID_W-1:0] id;
    logic                         found;
    id    = '0;
    found = 1'b0;
    for (int i = 31; i >= 16; i--) begin
      if (!found && pend[i]) begin
        id    = i[irq_pkg::IRQ_ID_W-1:0];
        found = 1'b1;
      end
    end
    if (!found && pend[11]) begin
      id    = 5'd11;
      found = 1'b1;
    end
    if (!found && pend[3]) begin
      id    = 5'd3;
      found = 1'b1;
    end
    if (!found && pend[7]) begin
      id = 5'd7;
    end
    return id;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Register model
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mdl_mip <= '0;
      mdl_mie <= '0;
      mdl_en  <= 1'b0;
    end else begin
      mdl_mip <= irq_i & irq_pkg::IRQ_MASK;
      if (csr_valid_i && csr_req_i.we && csr_req_i.addr == irq_pkg::CSR_MIE) begin
        mdl_mie <= csr_req_i.wdata & irq_pkg::IRQ_MASK;
      end
      if (csr_valid_i && csr_req_i.we && csr_req_i.addr == irq_pkg::CSR_MSTATUS) begin
        mdl_en <= csr_req_i.wdata[irq_pkg::MSTATUS_MIE_BIT];
      end
    end
  end

  assign mdl_pend = mdl_mip & mdl_mie;
  assign exp_id   = winner(mdl_pend);

  // Expected response, taken before any write lands
  always_comb begin
    exp_rsp = '0;
    if (csr_req_i.addr == irq_pkg::CSR_MSTATUS) begin
      exp_rsp.rdata[irq_pkg::MSTATUS_MIE_BIT] = mdl_en;
    end else if (csr_req_i.addr == irq_pkg::CSR_MIE) begin
      exp_rsp.rdata = mdl_mie;
    end else if (csr_req_i.addr == irq_pkg::CSR_MIP) begin
      exp_rsp.rdata = mdl_mip;
    end else begin
      exp_rsp.err = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (csr_valid_i) begin
      exp_rsp_q <= exp_rsp;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  a_reset: assert property (@(posedge clk_i) rst_i |=> !csr_rvalid_o && !irq_req_o
                            && !irq_wu_o && !m_irq_enable_o && irq_id_o == '0)
    else begin
      $error("error reset_outputs: expected 0 actual %h",
             $sampled({csr_rvalid_o, irq_req_o, irq_wu_o, m_irq_enable_o, irq_id_o}));
      failed = 1'b1;
    end

  // Response strobe follows the request by one cycle
  a_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
                             csr_rvalid_o == $past(csr_valid_i))
    else begin
      $error("error csr_rvalid: response strobe did not follow the request strobe");
      failed = 1'b1;
    end

  a_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
                          csr_rvalid_o |-> csr_rsp_o == exp_rsp_q)
    else begin
      $error("error csr_rsp: expected %h actual %h", $sampled(exp_rsp_q),
             $sampled(csr_rsp_o));
      failed = 1'b1;
    end

  // Global enable follows the last mstatus write
  a_enable: assert property (@(posedge clk_i) disable iff (rst_i)
                             m_irq_enable_o == mdl_en)
    else begin
      $error("error m_irq_enable: expected %b actual %b", $sampled(mdl_en),
             $sampled(m_irq_enable_o));
      failed = 1'b1;
    end

  // Wakeup ignores mstatus.MIE
  a_wakeup: assert property (@(posedge clk_i) disable iff (rst_i)
                             irq_wu_o == |mdl_pend)
    else begin
      $error("error wakeup: expected %b actual %b", $sampled(|mdl_pend), $sampled(irq_wu_o));
      failed = 1'b1;
    end

  a_request: assert property (@(posedge clk_i) disable iff (rst_i)
                              irq_req_o == (mdl_en && |mdl_pend))
    else begin
      $error("error request: expected %b actual %b", $sampled(mdl_en && |mdl_pend),
             $sampled(irq_req_o));
      failed = 1'b1;
    end

  a_id: assert property (@(posedge clk_i) disable iff (rst_i)
                         mdl_en |-> irq_id_o == exp_id)
    else begin
      $error("error irq_id: expected %0d actual %0d", $sampled(exp_id), $sampled(irq_id_o));
      failed = 1'b1;
    end

endmodule

bind int_controller int_controller_props props (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .irq_i          (irq_i),
  .csr_valid_i    (csr_valid_i),
  .csr_req_i      (csr_req_i),
  .csr_rvalid_o   (csr_rvalid_o),
  .csr_rsp_o      (csr_rsp_o),
  .m_irq_enable_o (m_irq_enable_o),
  .irq_req_o      (irq_req_o),
  .irq_id_o       (irq_id_o),
  .irq_wu_o       (irq_wu_o)
);

// File: dv/int_controller_tb.sv
/* Testbench for the interrupt controller: random CSR traffic and interrupt lines.
   Checking is done by the bound assertion module. */

`timescale 1ns/100ps

module int_controller_tb;

  localparam int MAX_CYCLES = 1500;

  logic                         clk;
  logic                         rst;
  irq_pkg::irq_vec_t            irq;
  logic                         csr_valid;
  irq_pkg::csr_req_t            csr_req;
  logic                         csr_rvalid;
  irq_pkg::csr_rsp_t            csr_rsp;
  logic                         m_irq_enable;
  logic                         irq_req;
  logic [irq_pkg::IRQ_ID_W-1:0] irq_id;
  logic                         irq_wu;

  logic [31:0] lfsr_state;
  int          cycles;

  int_controller dut (
    .clk_i          (clk),
    .rst_i          (rst),
    .irq_i          (irq),
    .csr_valid_i    (csr_valid),
    .csr_req_i      (csr_req),
    .csr_rvalid_o   (csr_rvalid),
    .csr_rsp_o      (csr_rsp),
    .m_irq_enable_o (m_irq_enable),
    .irq_req_o      (irq_req),
    .irq_id_o       (irq_id),
    .irq_wu_o       (irq_wu)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // n fresh bits, one LFSR step each
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic csr_strobe(input logic we, input logic [11:0] addr, input logic [31:0] wdata);
    @(posedge clk);
    csr_valid     <= 1'b1;
    csr_req.we    <= we;
    csr_req.addr  <= addr;
    csr_req.wdata <= wdata;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      csr_valid <= 1'b0;
    end
  endtask

  // One of the three CSRs or any 12-bit address, then a gap of 0 or 1
  task automatic random_csr_access();
    logic [31:0] sel;
    logic [31:0] addr;
    logic [31:0] we;
    logic [31:0] wdata;
    logic [31:0] gap;
    sel   = rand_bits(2);
    addr  = rand_bits(12);
    we    = rand_bits(1);
    wdata = rand_bits(32);
    gap   = rand_bits(1);
    case (sel[1:0])
      2'd0:    addr[11:0] = irq_pkg::CSR_MSTATUS;
      2'd1:    addr[11:0] = irq_pkg::CSR_MIE;
      2'd2:    addr[11:0] = irq_pkg::CSR_MIP;
      default: addr[11:0] = addr[11:0];
    endcase
    csr_strobe(we[0], addr[11:0], wdata);
    idle_cycles(int'(gap));
  endtask

  // Random lines for one cycle; half the time only the low 16 so 3, 7, 11 can win
  // Op 0 writes mie, 1 reads mip, 2 writes mip, 3 reads mie, rest idle
  task automatic irq_cycle();
    logic [31:0] lines;
    logic [31:0] low_only;
    logic [31:0] op;
    logic [31:0] wdata;
    lines    = rand_bits(32);
    low_only = rand_bits(1);
    op       = rand_bits(3);
    wdata    = rand_bits(32);
    @(posedge clk);
    irq           <= low_only[0] ? (lines & 32'h0000_FFFF) : lines;
    csr_valid     <= (op[2:0] < 3'd4);
    csr_req.we    <= (op[2:0] == 3'd0) || (op[2:0] == 3'd2);
    csr_req.addr  <= (op[2:0] == 3'd0 || op[2:0] == 3'd3) ? irq_pkg::CSR_MIE
                                                           : irq_pkg::CSR_MIP;
    csr_req.wdata <= wdata;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock, timeout, failure watch
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  always @(negedge clk) begin
    if (dut.props.failed) begin
      $display("=== FAIL ===");
      $fatal(1, "assertion failure reported by the bound checker");
    end else if (cycles >= MAX_CYCLES) begin
      $display("=== FAIL ===");
      $fatal(1, "timeout after %0d cycles", cycles);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Phases
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst        = 1'b1;
    irq        = '0;
    csr_valid  = 1'b0;
    csr_req    = '0;
    lfsr_state = 32'h54b5_2e11;

    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // Reset values, then mie reads back zero
    csr_strobe(1'b0, irq_pkg::CSR_MIE, 32'h0);
    idle_cycles(2);

    // Random CSR traffic with quiet lines
    repeat (200) random_csr_access();

    // Lines and mie writes, global enable off
    csr_strobe(1'b1, irq_pkg::CSR_MSTATUS, 32'h0);
    idle_cycles(1);
    repeat (400) irq_cycle();

    // Same with global enable on
    csr_strobe(1'b1, irq_pkg::CSR_MSTATUS, 32'h1 << irq_pkg::MSTATUS_MIE_BIT);
    idle_cycles(1);
    repeat (400) irq_cycle();
    idle_cycles(3);

    if (dut.props.failed) begin
      $display("=== FAIL ===");
      $fatal(1, "assertion failure reported by the bound checker");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// File: hw/int_controller.sv
/* Top level of the interrupt subsystem: CSR decode, per-line cells, arbiter.
   Connect irq_i to the sources and drive the CSR strobe port. */

`timescale 1ns/100ps

module int_controller (
  input  logic                         clk_i,
  input  logic                         rst_i,

  // Interrupt sources
  input  irq_pkg::irq_vec_t            irq_i,

  // CSR strobe port
  input  logic                         csr_valid_i,
  input  irq_pkg::csr_req_t            csr_req_i,
  output logic                         csr_rvalid_o,
  output irq_pkg::csr_rsp_t            csr_rsp_o,

  // Arbiter results and global enable
  output logic                         m_irq_enable_o,
  output logic                         irq_req_o,
  output logic [irq_pkg::IRQ_ID_W-1:0] irq_id_o,
  output logic                         irq_wu_o
);

  // Broadcast from CSR decode
  logic              mie_we;
  irq_pkg::irq_vec_t mie_wdata;

  // Gathered cell outputs
  irq_pkg::irq_vec_t mip_vec;
  irq_pkg::irq_vec_t mie_vec;
  irq_pkg::irq_vec_t pend_vec;

  ////////////////////////////////////////////////////////////////////////////
  // CSR decode
  ////////////////////////////////////////////////////////////////////////////

  irq_csr csr_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .csr_valid_i    (csr_valid_i),
    .csr_req_i      (csr_req_i),
    .csr_rvalid_o   (csr_rvalid_o),
    .csr_rsp_o      (csr_rsp_o),
    .mip_i          (mip_vec),
    .mie_i          (mie_vec),
    .mie_we_o       (mie_we),
    .mie_wdata_o    (mie_wdata),
    .m_irq_enable_o (m_irq_enable_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Line cells, only where implemented
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < irq_pkg::NUM_IRQ; g++) begin : gen_line
    if (irq_pkg::IRQ_MASK[g]) begin : gen_cell
      irq_line line_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .irq_i       (irq_i[g]),
        .mie_we_i    (mie_we),
        .mie_wdata_i (mie_wdata[g]),
        .mip_o       (mip_vec[g]),
        .mie_o       (mie_vec[g]),
        .pend_o      (pend_vec[g])
      );
    end else begin : gen_tie
      // Reserved position reads zero
      assign mip_vec[g]  = 1'b0;
      assign mie_vec[g]  = 1'b0;
      assign pend_vec[g] = 1'b0;
    end
  end

  // Priority pick
  irq_arbiter arbiter_i (
    .pend_i         (pend_vec),
    .m_irq_enable_i (m_irq_enable_o),
    .irq_req_o      (irq_req_o),
    .irq_id_o       (irq_id_o),
    .irq_wu_o       (irq_wu_o)
  );

endmodule

// File: hw/irq_arbiter.sv
/* Fixed-priority pick among pending, enabled lines.
   Produces the request, the winning identifier and the wakeup. */

`timescale 1ns/100ps

module irq_arbiter (
  input  irq_pkg::irq_vec_t           pend_i,
  input  logic                        m_irq_enable_i,
  output logic                        irq_req_o,
  output logic [irq_pkg::IRQ_ID_W-1:0] irq_id_o,
  output logic                        irq_wu_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Priority select
  ////////////////////////////////////////////////////////////////////////////

  // Lowest priority first, each later hit overrides
  // Order low to high: timer, software, external, fast 16..31
  always_comb begin
    irq_id_o = '0;

    if (pend_i[irq_pkg::IRQ_TIMER]) begin
      irq_id_o = irq_pkg::IRQ_TIMER[irq_pkg::IRQ_ID_W-1:0];
    end

    // Software beats timer
    if (pend_i[irq_pkg::IRQ_SOFT]) begin
      irq_id_o = irq_pkg::IRQ_SOFT[irq_pkg::IRQ_ID_W-1:0];
    end

    // External beats both
    if (pend_i[irq_pkg::IRQ_EXT]) begin
      irq_id_o = irq_pkg::IRQ_EXT[irq_pkg::IRQ_ID_W-1:0];
    end

    // Fast lines, highest index wins
    for (int i = irq_pkg::IRQ_FAST_LO; i <= irq_pkg::IRQ_FAST_HI; i++) begin
      if (pend_i[i]) begin
        irq_id_o = i[irq_pkg::IRQ_ID_W-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request and wakeup
  ////////////////////////////////////////////////////////////////////////////

  // Wakeup ignores the global enable
  assign irq_wu_o  = |pend_i;

  // Request needs mstatus.MIE
  assign irq_req_o = irq_wu_o && m_irq_enable_i;

endmodule

// File: hw/irq_csr.sv
/* CSR decode for mstatus, mie and mip, with the mstatus.MIE flop.
   Answers every strobe one cycle later and broadcasts mie writes to the line cells. */

`timescale 1ns/100ps

module irq_csr (
  input  logic              clk_i,
  input  logic              rst_i,

  // Single-cycle CSR strobe
  input  logic              csr_valid_i,
  input  irq_pkg::csr_req_t csr_req_i,
  output logic              csr_rvalid_o,
  output irq_pkg::csr_rsp_t csr_rsp_o,

  // Line cell state
  input  irq_pkg::irq_vec_t mip_i,
  input  irq_pkg::irq_vec_t mie_i,

  // mie broadcast
  output logic              mie_we_o,
  output irq_pkg::irq_vec_t mie_wdata_o,

  // Global enable
  output logic              m_irq_enable_o
);

  logic        sel_mstatus;
  logic        sel_mie;
  logic        sel_mip;
  logic        addr_err;
  logic [31:0] rdata;
  logic        m_irq_enable_q;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  assign sel_mstatus = (csr_req_i.addr == irq_pkg::CSR_MSTATUS);
  assign sel_mie     = (csr_req_i.addr == irq_pkg::CSR_MIE);
  assign sel_mip     = (csr_req_i.addr == irq_pkg::CSR_MIP);
  assign addr_err    = !(sel_mstatus || sel_mie || sel_mip);

  // Read mux, old value also returned on writes
  always_comb begin
    rdata = '0;
    if (sel_mstatus) begin
      // Only MIE is implemented
      rdata[irq_pkg::MSTATUS_MIE_BIT] = m_irq_enable_q;
    end else if (sel_mie) begin
      rdata = mie_i;
    end else if (sel_mip) begin
      rdata = mip_i;
    end
  end

  // mie write goes straight to the cells, unimplemented bits stripped
  assign mie_we_o    = csr_valid_i && csr_req_i.we && sel_mie;
  assign mie_wdata_o = csr_req_i.wdata & irq_pkg::IRQ_MASK;

  ////////////////////////////////////////////////////////////////////////////
  // mstatus.MIE and response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      m_irq_enable_q <= 1'b0;
    end else if (csr_valid_i && csr_req_i.we && sel_mstatus) begin
      m_irq_enable_q <= csr_req_i.wdata[irq_pkg::MSTATUS_MIE_BIT];
    end
  end

  // Response strobe, one cycle after request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      csr_rvalid_o <= 1'b0;
    end else begin
      csr_rvalid_o <= csr_valid_i;
    end
  end

  // Response payload, bad address reads zero
  always_ff @(posedge clk_i) begin
    if (csr_valid_i) begin
      csr_rsp_o.err   <= addr_err;
      csr_rsp_o.rdata <= rdata;
    end
  end

  assign m_irq_enable_o = m_irq_enable_q;

endmodule

// File: hw/irq_line.sv
/* One interrupt line: sampled pending bit plus its enable bit.
   Instantiated once per implemented line by the top level. */

`timescale 1ns/100ps

module irq_line (
  input  logic clk_i,
  input  logic rst_i,
  input  logic irq_i,
  input  logic mie_we_i,
  input  logic mie_wdata_i,
  output logic mip_o,
  output logic mie_o,
  output logic pend_o
);

  logic mip_q;
  logic mie_q;

  // Sample the line every cycle, enable only on mie write
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mip_q <= 1'b0;
      mie_q <= 1'b0;
    end else begin
      mip_q <= irq_i;
      if (mie_we_i) begin
        mie_q <= mie_wdata_i;
      end
    end
  end

  assign mip_o  = mip_q;
  assign mie_o  = mie_q;

  // Pending and enabled
  assign pend_o = mip_q && mie_q;

endmodule

// File: hw/irq_pkg.sv
/* Shared constants and types of the interrupt controller subsystem.
   RTL and testbench files refer to them by scoped name. */

package irq_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Interrupt lines and identifier width
  localparam int NUM_IRQ  = 32;
  localparam int IRQ_ID_W = 5;

  // CSR address width
  localparam int CSR_ADDR_W = 12;

  ////////////////////////////////////////////////////////////////////////////
  // CSR map
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIE     = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIP     = 12'h344;

  // Global enable within mstatus
  localparam int MSTATUS_MIE_BIT = 3;

  // Standard machine lines, fast lines above
  localparam int IRQ_SOFT    = 3;
  localparam int IRQ_TIMER   = 7;
  localparam int IRQ_EXT     = 11;
  localparam int IRQ_FAST_LO = 16;
  localparam int IRQ_FAST_HI = 31;

  // One bit per interrupt line
  typedef logic [NUM_IRQ-1:0] irq_vec_t;

  // Implemented lines: 3, 7, 11 and 16..31
  localparam irq_vec_t IRQ_MASK = 32'hFFFF_0888;

  // One CSR access, 45 bits
  typedef struct packed {
    logic                  we;
    logic [CSR_ADDR_W-1:0] addr;
    logic [31:0]           wdata;
  } csr_req_t;

  // One CSR response, 33 bits
  typedef struct packed {
    logic        err;
    logic [31:0] rdata;
  } csr_rsp_t;

endpackage

// File: list.f
hw/irq_pkg.sv
hw/irq_line.sv
hw/irq_csr.sv
hw/irq_arbiter.sv
hw/int_controller.sv
dv/int_controller_props.sv
dv/int_controller_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; a $fatal gives a failing exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
  -f list.f --top-module int_controller_tb -o int_controller_sim &&
./obj_dir/int_controller_sim +verilator+error+limit+10 ||
{ echo "simulation failed"; exit 1; }
